// File: vlog.f
+incdir+tb
logic/rv_core_pkg.sv
logic/regfile.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/commit_stage.sv
logic/rv_core.sv
tb/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: tb/rv_ref_model.svh
// instruction-level model of the core and random instruction source, included inside the testbench
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

xlen_t ref_regs [32] = '{default: '0};
xlen_t ref_pc = RESET_PC;

function automatic xlen_t alu_result(logic [2:0] f3, logic alt, logic reg_form,
                                     xlen_t a, xlen_t b);
  logic signed [63:0] sa;
  sa = a;
  case (f3)
    3'd0: return (alt && reg_form) ? a - b : a + b;
    3'd1: return a << b[5:0];
    3'd2: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    3'd3: return (a < b) ? 64'd1 : 64'd0;
    3'd4: return a ^ b;
    3'd5: begin
      if (alt) begin
        return sa >>> b[5:0];
      end
      return a >> b[5:0];
    end
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
  case (f3)
    3'd0: return a == b;
    3'd1: return a != b;
    3'd4: return $signed(a) < $signed(b);
    3'd5: return $signed(a) >= $signed(b);
    3'd6: return a < b;
    3'd7: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// runs one instruction on the model state, returns what the retire port should show
task automatic execute_inst(input inst_t inst, input xlen_t pc, output logic wen,
                            output reg_idx_t rd, output xlen_t data, output logic putch,
                            output logic [7:0] ch);
  logic [2:0] f3;
  xlen_t      a;
  xlen_t      b;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;
  xlen_t      next_pc;
  f3      = inst[14:12];
  rd      = inst[11:7];
  a       = ref_regs[inst[19:15]];
  b       = ref_regs[inst[24:20]];
  imm_i   = {{52{inst[31]}}, inst[31:20]};
  imm_u   = {{32{inst[31]}}, inst[31:12], 12'h000};
  imm_b   = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_j   = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  next_pc = pc + 64'd4;
  wen     = 1'b0;
  data    = '0;
  putch   = 1'b0;
  ch      = '0;
  if (inst == 32'h0000_007b) begin
    putch = 1'b1;
    data  = ref_regs[10];
    ch    = ref_regs[10][7:0];
  end else begin
    case (inst[6:0])
      OPC_OP: begin
        wen  = 1'b1;
        data = alu_result(f3, inst[30], 1'b1, a, b);
      end
      OPC_OP_IMM: begin
        wen  = 1'b1;
        data = alu_result(f3, inst[30], 1'b0, a, imm_i);
      end
      OPC_LUI: begin
        wen  = 1'b1;
        data = imm_u;
      end
      OPC_AUIPC: begin
        wen  = 1'b1;
        data = pc + imm_u;
      end
      OPC_JAL: begin
        wen     = 1'b1;
        data    = pc + 64'd4;
        next_pc = pc + imm_j;
      end
      OPC_JALR: begin
        wen     = 1'b1;
        data    = pc + 64'd4;
        next_pc = (a + imm_i) & ~64'd1;
      end
      OPC_BRANCH: begin
        if (branch_taken(f3, a, b)) begin
          next_pc = pc + imm_b;
        end
      end
      default: ;
    endcase
  end
  if (rd == 5'd0) begin
    wen = 1'b0;
  end
  if (wen) begin
    ref_regs[rd] = data;
  end
  ref_pc = next_pc;
endtask

////////////////////
// stimulus

function automatic inst_t random_inst();
  logic [31:0] r;
  logic [31:0] s;
  reg_idx_t    rd;
  reg_idx_t    rs1;
  reg_idx_t    rs2;
  logic [2:0]  f3;
  logic [11:0] imm12;
  logic [12:0] off13;
  logic [20:0] off21;
  logic [6:0]  opc;
  r   = next_random();
  s   = next_random();
  rd  = r[8:4];
  rs1 = r[13:9];
  rs2 = r[18:14];
  f3  = r[21:19];
  case (r[3:0])
    4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
      // funct7 0x20 only for sub and sra
      return {1'b0, r[22] && (f3 == 3'd0 || f3 == 3'd5), 5'b0, rs2, rs1, f3, rd, OPC_OP};
    end
    4'd5, 4'd6, 4'd7: begin
      imm12 = s[11:0];
      if (f3 == 3'd1) begin
        imm12 = {6'b0, s[5:0]};
      end
      if (f3 == 3'd5) begin
        imm12 = {1'b0, s[6], 4'b0, s[5:0]};
      end
      return {imm12, rs1, f3, rd, OPC_OP_IMM};
    end
    4'd8: return {s[19:0], rd, OPC_LUI};
    4'd9: return {s[19:0], rd, OPC_AUIPC};
    4'd10: begin
      off21 = {s[20:2], 2'b00};
      return {off21[20], off21[10:1], off21[11], off21[19:12], rd, OPC_JAL};
    end
    4'd11: begin
      // rs1 + imm lands on a word boundary
      imm12 = {s[11:2], 2'b00} + {10'b0, (2'b00 - ref_regs[rs1][1:0])};
      return {imm12, rs1, 3'b000, rd, OPC_JALR};
    end
    4'd12, 4'd13: begin
      off13 = {s[12:2], 2'b00};
      if (f3[2:1] == 2'b01) begin
        f3[2] = 1'b1;
      end
      return {off13[12], off13[10:5], rs2, rs1, f3, off13[4:1], off13[11], OPC_BRANCH};
    end
    4'd14: return PUTCH_INST;
    default: begin
      // load, store, fence, system and the W groups
      case (r[24:22])
        3'd0:    opc = 7'h03;
        3'd1:    opc = 7'h23;
        3'd2:    opc = 7'h0f;
        3'd3:    opc = 7'h73;
        3'd4:    opc = 7'h1b;
        default: opc = 7'h3b;
      endcase
      return {s[24:0], opc};
    end
  endcase
endfunction

`endif

// File: tb/rv_core_tb.sv
// testbench for the core, random instruction memory with random ack delay checked against a model
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

  localparam xlen_t       RESET_PC        = 64'h0000_0000_8000_0000;
  localparam logic [31:0] SEED            = 32'h592d45ec;
  localparam int unsigned NUM_INSTS       = 250;
  localparam int unsigned MAX_ACK_DELAY   = 7;
  // 300 instruction times of 12 cycles
  localparam int unsigned WATCHDOG_CYCLES = (NUM_INSTS + 50) * 12;

  logic       clk;
  logic       rst_n;
  logic       ibus_req;
  xlen_t      ibus_addr;
  logic       ibus_ack = 1'b0;
  inst_t      ibus_rdata = '0;
  logic       retire_valid;
  xlen_t      retire_pc;
  logic       retire_rd_wen;
  reg_idx_t   retire_rd;
  xlen_t      retire_data;
  logic       putch_valid;
  logic [7:0] putch_char;

  logic [31:0] lcg_state = SEED;
  logic        req_seen = 1'b0;
  int unsigned delay_left = 0;
  int unsigned up_cycles = 0;
  int unsigned errors = 0;
  int unsigned fetch_count = 0;
  int unsigned retire_count = 0;
  int unsigned putch_count = 0;
  inst_t       mem_word;
  inst_t       fetch_inst_q[$];
  xlen_t       fetch_pc_q[$];

  // two LCG steps, upper halves only
  function automatic logic [31:0] next_random();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  `include "rv_ref_model.svh"

  rv_core #(
    .RESET_PC (RESET_PC)
  ) i_rv_core (
    .clk             (clk),
    .i_rst_n         (rst_n),
    .o_ibus_req      (ibus_req),
    .o_ibus_addr     (ibus_addr),
    .i_ibus_ack      (ibus_ack),
    .i_ibus_rdata    (ibus_rdata),
    .o_retire_valid  (retire_valid),
    .o_retire_pc     (retire_pc),
    .o_retire_rd_wen (retire_rd_wen),
    .o_retire_rd     (retire_rd),
    .o_retire_data   (retire_data),
    .o_putch_valid   (putch_valid),
    .o_putch_char    (putch_char)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(string what, xlen_t got, xlen_t exp);
    $display("FAILED %0t: %s got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  task automatic check_retire();
    inst_t      inst;
    xlen_t      pc;
    logic       exp_wen;
    reg_idx_t   exp_rd;
    xlen_t      exp_data;
    logic       exp_putch;
    logic [7:0] exp_char;
    if (fetch_pc_q.size() == 0) begin
      $display("error at %0t: retire without an outstanding fetch", $time);
      errors++;
      return;
    end
    inst = fetch_inst_q.pop_front();
    pc   = fetch_pc_q.pop_front();
    retire_count++;
    if (retire_pc !== pc) begin
      report_mismatch("retire pc", retire_pc, pc);
    end
    execute_inst(inst, pc, exp_wen, exp_rd, exp_data, exp_putch, exp_char);
    if (retire_rd_wen !== exp_wen) begin
      report_mismatch($sformatf("rd_wen of %h", inst), 64'(retire_rd_wen), 64'(exp_wen));
    end
    if (exp_wen && retire_rd !== exp_rd) begin
      report_mismatch($sformatf("rd of %h", inst), 64'(retire_rd), 64'(exp_rd));
    end
    if (exp_wen && retire_data !== exp_data) begin
      report_mismatch($sformatf("result of %h", inst), retire_data, exp_data);
    end
    if (putch_valid !== exp_putch) begin
      report_mismatch($sformatf("putch strobe of %h", inst), 64'(putch_valid), 64'(exp_putch));
    end
    if (exp_putch) begin
      putch_count++;
      if (putch_char !== exp_char) begin
        report_mismatch("putch char", 64'(putch_char), 64'(exp_char));
      end
    end
  endtask

  ////////////////////
  // monitor and instruction memory

  always @(posedge clk) begin
    if (rst_n) begin
      if (up_cycles == 0) begin
        if (ibus_req !== 1'b0 || retire_valid !== 1'b0 || putch_valid !== 1'b0) begin
          $display("error at %0t: core outputs not idle after reset", $time);
          errors++;
        end
      end else if (up_cycles == 1) begin
        if (ibus_req !== 1'b1) begin
          $display("error at %0t: no fetch request in the first cycle after reset", $time);
          errors++;
        end
        if (ibus_addr !== RESET_PC) begin
          report_mismatch("first fetch address", ibus_addr, RESET_PC);
        end
      end
      up_cycles++;

      if (retire_valid) begin
        check_retire();
      end else if (putch_valid) begin
        $display("error at %0t: character strobe without a retire", $time);
        errors++;
      end

      // ack is a single pulse, request drops after it
      if (ibus_ack) begin
        ibus_ack <= 1'b0;
      end else if (ibus_req) begin
        if (!req_seen) begin
          req_seen   = 1'b1;
          delay_left = next_random() % (MAX_ACK_DELAY + 1);
        end
        if (delay_left == 0) begin
          if (ibus_addr !== ref_pc) begin
            report_mismatch("fetch address", ibus_addr, ref_pc);
          end
          if (fetch_pc_q.size() != 0) begin
            $display("error at %0t: fetch before the previous instruction retired", $time);
            errors++;
          end
          mem_word = random_inst();
          fetch_inst_q.push_back(mem_word);
          fetch_pc_q.push_back(ibus_addr);
          fetch_count++;
          req_seen = 1'b0;
          ibus_rdata <= mem_word;
          ibus_ack   <= 1'b1;
        end else begin
          delay_left--;
        end
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    while (retire_count < NUM_INSTS) begin
      @(posedge clk);
    end
    @(posedge clk);
    $display("summary: %0d fetched, %0d retired, %0d characters, %0d errors",
             fetch_count, retire_count, putch_count, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: only %0d of %0d instructions retired", retire_count, NUM_INSTS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: logic/rv_core.sv
// top level of the single-issue RV64 core, connects the stages and the register file
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic     clk,
  input  logic     i_rst_n,
  output logic     o_ibus_req,
  output xlen_t    o_ibus_addr,
  input  logic     i_ibus_ack,
  input  inst_t    i_ibus_rdata,
  output logic     o_retire_valid,
  output xlen_t    o_retire_pc,
  output logic     o_retire_rd_wen,
  output reg_idx_t o_retire_rd,
  output xlen_t    o_retire_data,
  output logic     o_putch_valid,
  output logic [7:0] o_putch_char
);

  // fetch -> decode
  logic       fetched;
  xlen_t      f_pc;
  inst_t      f_inst;

  // decode <-> regfile
  reg_idx_t   rs1_idx;
  reg_idx_t   rs2_idx;
  xlen_t      rs1_data;
  xlen_t      rs2_data;

  // decode -> execute
  logic       decoded;
  xlen_t      d_pc;
  xlen_t      d_op_a;
  xlen_t      d_op_b;
  xlen_t      d_rs2_val;
  xlen_t      d_imm;
  alu_op_e    d_alu_op;
  ctrl_kind_e d_kind;
  logic [2:0] d_funct3;
  reg_idx_t   d_rd;
  logic       d_rd_wen;

  // execute -> commit, next pc back to fetch
  logic       executed;
  xlen_t      e_pc;
  xlen_t      e_next_pc;
  xlen_t      e_result;
  reg_idx_t   e_rd;
  logic       e_rd_wen;
  logic       e_putch;

  // commit -> regfile and fetch
  logic       reg_wen;
  reg_idx_t   reg_rd;
  xlen_t      reg_data;
  logic       committed;

  ////////////////////
  // stages

  fetch_stage #(
    .RESET_PC (RESET_PC)
  ) u_fetch_stage (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_ibus_ack   (i_ibus_ack),
    .i_ibus_rdata (i_ibus_rdata),
    .i_executed   (executed),
    .i_next_pc    (e_next_pc),
    .i_committed  (committed),
    .o_ibus_req   (o_ibus_req),
    .o_ibus_addr  (o_ibus_addr),
    .o_fetched    (fetched),
    .o_pc         (f_pc),
    .o_inst       (f_inst)
  );

  decode_stage u_decode_stage (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_fetched  (fetched),
    .i_pc       (f_pc),
    .i_inst     (f_inst),
    .o_rs1      (rs1_idx),
    .o_rs2      (rs2_idx),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_decoded  (decoded),
    .o_pc       (d_pc),
    .o_op_a     (d_op_a),
    .o_op_b     (d_op_b),
    .o_rs2_val  (d_rs2_val),
    .o_imm      (d_imm),
    .o_alu_op   (d_alu_op),
    .o_kind     (d_kind),
    .o_funct3   (d_funct3),
    .o_rd       (d_rd),
    .o_rd_wen   (d_rd_wen)
  );

  execute_stage u_execute_stage (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_decoded  (decoded),
    .i_pc       (d_pc),
    .i_op_a     (d_op_a),
    .i_op_b     (d_op_b),
    .i_rs2_val  (d_rs2_val),
    .i_imm      (d_imm),
    .i_alu_op   (d_alu_op),
    .i_kind     (d_kind),
    .i_funct3   (d_funct3),
    .i_rd       (d_rd),
    .i_rd_wen   (d_rd_wen),
    .o_executed (executed),
    .o_pc       (e_pc),
    .o_next_pc  (e_next_pc),
    .o_result   (e_result),
    .o_rd       (e_rd),
    .o_rd_wen   (e_rd_wen),
    .o_putch    (e_putch)
  );

  commit_stage u_commit_stage (
    .clk             (clk),
    .i_rst_n         (i_rst_n),
    .i_executed      (executed),
    .i_pc            (e_pc),
    .i_result        (e_result),
    .i_rd            (e_rd),
    .i_rd_wen        (e_rd_wen),
    .i_putch         (e_putch),
    .o_reg_wen       (reg_wen),
    .o_reg_rd        (reg_rd),
    .o_reg_data      (reg_data),
    .o_committed     (committed),
    .o_retire_valid  (o_retire_valid),
    .o_retire_pc     (o_retire_pc),
    .o_retire_rd_wen (o_retire_rd_wen),
    .o_retire_rd     (o_retire_rd),
    .o_retire_data   (o_retire_data),
    .o_putch_valid   (o_putch_valid),
    .o_putch_char    (o_putch_char)
  );

  regfile u_regfile (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_rs1      (rs1_idx),
    .i_rs2      (rs2_idx),
    .i_wen      (reg_wen),
    .i_rd       (reg_rd),
    .i_wdata    (reg_data),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

endmodule

// File: logic/commit_stage.sv
// register writeback, retire trace record and character output
`timescale 1ns/1ps

module commit_stage import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_executed,
  input  xlen_t      i_pc,
  input  xlen_t      i_result,
  input  reg_idx_t   i_rd,
  input  logic       i_rd_wen,
  input  logic       i_putch,
  output logic       o_reg_wen,
  output reg_idx_t   o_reg_rd,
  output xlen_t      o_reg_data,
  output logic       o_committed,
  output logic       o_retire_valid,
  output xlen_t      o_retire_pc,
  output logic       o_retire_rd_wen,
  output reg_idx_t   o_retire_rd,
  output xlen_t      o_retire_data,
  output logic       o_putch_valid,
  output logic [7:0] o_putch_char
);

  // write lands on the edge that ends the executed cycle
  assign o_reg_wen  = i_executed && i_rd_wen;
  assign o_reg_rd   = i_rd;
  assign o_reg_data = i_result;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_committed    <= 1'b0;
      o_retire_valid <= 1'b0;
      o_putch_valid  <= 1'b0;
    end else begin
      o_committed    <= i_executed;
      o_retire_valid <= i_executed;
      o_putch_valid  <= i_executed && i_putch;
    end
  end

  always_ff @(posedge clk) begin
    if (i_executed) begin
      o_retire_pc     <= i_pc;
      o_retire_rd_wen <= i_rd_wen;
      o_retire_rd     <= i_rd;
      o_retire_data   <= i_result;
    end
    if (i_executed && i_putch) begin
      o_putch_char <= i_result[7:0];
    end
  end

  a_putch_retire: assert property (@(posedge clk) disable iff (!i_rst_n)
    o_putch_valid |-> (o_retire_valid && !o_retire_rd_wen));

endmodule

// File: logic/execute_stage.sv
// alu, branch compare and next pc, results registered toward commit
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_decoded,
  input  xlen_t      i_pc,
  input  xlen_t      i_op_a,
  input  xlen_t      i_op_b,
  input  xlen_t      i_rs2_val,
  input  xlen_t      i_imm,
  input  alu_op_e    i_alu_op,
  input  ctrl_kind_e i_kind,
  input  logic [2:0] i_funct3,
  input  reg_idx_t   i_rd,
  input  logic       i_rd_wen,
  output logic       o_executed,
  output xlen_t      o_pc,
  output xlen_t      o_next_pc,
  output xlen_t      o_result,
  output reg_idx_t   o_rd,
  output logic       o_rd_wen,
  output logic       o_putch
);

  logic [5:0] shamt;
  xlen_t      alu_res;
  xlen_t      pc_plus4;
  xlen_t      br_target;
  logic       taken;
  xlen_t      result_d;
  xlen_t      next_pc_d;

  assign shamt     = i_op_b[5:0];
  assign pc_plus4  = i_pc + INST_BYTES;
  assign br_target = i_pc + i_imm;

  ////////////////////
  // alu

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  alu_res = i_op_a + i_op_b;
      ALU_SUB:  alu_res = i_op_a - i_op_b;
      ALU_AND:  alu_res = i_op_a & i_op_b;
      ALU_OR:   alu_res = i_op_a | i_op_b;
      ALU_XOR:  alu_res = i_op_a ^ i_op_b;
      ALU_SLL:  alu_res = i_op_a << shamt;
      ALU_SRL:  alu_res = i_op_a >> shamt;
      ALU_SRA:  alu_res = $signed(i_op_a) >>> shamt;
      ALU_SLT:  alu_res = {63'b0, $signed(i_op_a) < $signed(i_op_b)};
      ALU_SLTU: alu_res = {63'b0, i_op_a < i_op_b};
      default:  alu_res = i_op_a + i_op_b;
    endcase
  end

  // branch operand b is the raw rs2 value
  always_comb begin
    case (i_funct3)
      3'b000:  taken = (i_op_a == i_rs2_val);
      3'b001:  taken = (i_op_a != i_rs2_val);
      3'b100:  taken = ($signed(i_op_a) < $signed(i_rs2_val));
      3'b101:  taken = ($signed(i_op_a) >= $signed(i_rs2_val));
      3'b110:  taken = (i_op_a < i_rs2_val);
      3'b111:  taken = (i_op_a >= i_rs2_val);
      default: taken = 1'b0;
    endcase
  end

  ////////////////////
  // result and next pc

  always_comb begin
    result_d  = alu_res;
    next_pc_d = pc_plus4;
    case (i_kind)
      KIND_BRANCH: begin
        if (taken) begin
          next_pc_d = br_target;
        end
      end
      KIND_JAL: begin
        result_d  = pc_plus4;
        next_pc_d = br_target;
      end
      KIND_JALR: begin
        result_d  = pc_plus4;
        next_pc_d = {alu_res[63:1], 1'b0};
      end
      KIND_PUTCH: result_d = i_op_a;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_executed <= 1'b0;
    end else begin
      o_executed <= i_decoded;
    end
  end

  always_ff @(posedge clk) begin
    if (i_decoded) begin
      o_pc      <= i_pc;
      o_next_pc <= next_pc_d;
      o_result  <= result_d;
      o_rd      <= i_rd;
      o_rd_wen  <= i_rd_wen;
      o_putch   <= (i_kind == KIND_PUTCH);
    end
  end

endmodule

// File: logic/decode_stage.sv
// instruction decoder, register read, immediate build and operand select
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
  input  logic       clk,
  input  logic       i_rst_n,
  input  logic       i_fetched,
  input  xlen_t      i_pc,
  input  inst_t      i_inst,
  output reg_idx_t   o_rs1,
  output reg_idx_t   o_rs2,
  input  xlen_t      i_rs1_data,
  input  xlen_t      i_rs2_data,
  output logic       o_decoded,
  output xlen_t      o_pc,
  output xlen_t      o_op_a,
  output xlen_t      o_op_b,
  output xlen_t      o_rs2_val,
  output xlen_t      o_imm,
  output alu_op_e    o_alu_op,
  output ctrl_kind_e o_kind,
  output logic [2:0] o_funct3,
  output reg_idx_t   o_rd,
  output logic       o_rd_wen
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  reg_idx_t   rd;
  logic       is_putch;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_b;
  xlen_t      imm_j;

  xlen_t      op_a_d;
  xlen_t      op_b_d;
  xlen_t      imm_d;
  alu_op_e    alu_d;
  ctrl_kind_e kind_d;
  logic       wen_d;

  // funct3 to alu op, sub only exists in reg-reg form
  function automatic alu_op_e alu_sel(logic [2:0] f3, logic alt_bit, logic allow_sub);
    case (f3)
      3'b000:  alu_sel = (alt_bit && allow_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  alu_sel = ALU_SLL;
      3'b010:  alu_sel = ALU_SLT;
      3'b011:  alu_sel = ALU_SLTU;
      3'b100:  alu_sel = ALU_XOR;
      3'b101:  alu_sel = alt_bit ? ALU_SRA : ALU_SRL;
      3'b110:  alu_sel = ALU_OR;
      default: alu_sel = ALU_AND;
    endcase
  endfunction

  assign opcode   = i_inst[6:0];
  assign funct3   = i_inst[14:12];
  assign alt      = i_inst[30];
  assign rd       = i_inst[11:7];
  assign is_putch = (i_inst == PUTCH_INST);

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // putch reads a0 through the rs1 port
  assign o_rs1 = is_putch ? REG_A0 : i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  always_comb begin
    op_a_d = i_rs1_data;
    op_b_d = i_rs2_data;
    imm_d  = imm_i;
    alu_d  = ALU_ADD;
    kind_d = KIND_PLAIN;
    wen_d  = 1'b0;
    if (is_putch) begin
      kind_d = KIND_PUTCH;
    end else begin
      case (opcode)
        OPC_OP: begin
          alu_d = alu_sel(funct3, alt, 1'b1);
          wen_d = 1'b1;
        end
        OPC_OP_IMM: begin
          op_b_d = imm_i;
          alu_d  = alu_sel(funct3, alt, 1'b0);
          wen_d  = 1'b1;
        end
        OPC_LUI: begin
          op_a_d = '0;
          op_b_d = imm_u;
          imm_d  = imm_u;
          wen_d  = 1'b1;
        end
        OPC_AUIPC: begin
          op_a_d = i_pc;
          op_b_d = imm_u;
          imm_d  = imm_u;
          wen_d  = 1'b1;
        end
        OPC_JAL: begin
          op_a_d = i_pc;
          op_b_d = imm_j;
          imm_d  = imm_j;
          kind_d = KIND_JAL;
          wen_d  = 1'b1;
        end
        OPC_JALR: begin
          op_b_d = imm_i;
          kind_d = KIND_JALR;
          wen_d  = 1'b1;
        end
        OPC_BRANCH: begin
          imm_d  = imm_b;
          kind_d = KIND_BRANCH;
        end
        // anything else retires as a no-op
        default: begin
          op_a_d = '0;
          op_b_d = '0;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_decoded <= 1'b0;
    end else begin
      o_decoded <= i_fetched;
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      o_pc      <= i_pc;
      o_op_a    <= op_a_d;
      o_op_b    <= op_b_d;
      o_rs2_val <= i_rs2_data;
      o_imm     <= imm_d;
      o_alu_op  <= alu_d;
      o_kind    <= kind_d;
      o_funct3  <= funct3;
      o_rd      <= rd;
      o_rd_wen  <= wen_d && (rd != '0);
    end
  end

endmodule

// File: logic/fetch_stage.sv
// program counter and instruction-port requester, one fetch per committed instruction
`timescale 1ns/1ps

module fetch_stage import rv_core_pkg::*; #(
  parameter xlen_t RESET_PC = 64'h0000_0000_8000_0000
) (
  input  logic  clk,
  input  logic  i_rst_n,
  input  logic  i_ibus_ack,
  input  inst_t i_ibus_rdata,
  input  logic  i_executed,
  input  xlen_t i_next_pc,
  input  logic  i_committed,
  output logic  o_ibus_req,
  output xlen_t o_ibus_addr,
  output logic  o_fetched,
  output xlen_t o_pc,
  output inst_t o_inst
);

  fetch_state_e state;
  xlen_t        pc;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state      <= FS_REQ;
      pc         <= RESET_PC;
      o_ibus_req <= 1'b0;
      o_fetched  <= 1'b0;
    end else begin
      o_fetched <= 1'b0;
      case (state)
        FS_REQ: begin
          if (o_ibus_req && i_ibus_ack) begin
            o_ibus_req <= 1'b0;
            o_fetched  <= 1'b1;
            state      <= FS_WAIT;
          end else begin
            // first request after reset
            o_ibus_req <= 1'b1;
          end
        end
        FS_WAIT: begin
          if (i_executed) begin
            pc <= i_next_pc;
          end
          if (i_committed) begin
            o_ibus_req <= 1'b1;
            state      <= FS_REQ;
          end
        end
        default: state <= FS_REQ;
      endcase
    end
  end

  // instruction word held until the next fetch
  always_ff @(posedge clk) begin
    if (o_ibus_req && i_ibus_ack) begin
      o_inst <= i_ibus_rdata;
    end
  end

  assign o_ibus_addr = pc;
  assign o_pc        = pc;

  a_req_hold: assert property (@(posedge clk) disable iff (!i_rst_n)
    (o_ibus_req && !i_ibus_ack) |=> (o_ibus_req && $stable(o_ibus_addr)));

endmodule

// File: logic/regfile.sv
// integer register file, two async read ports and one write port, x0 reads zero
`timescale 1ns/1ps

module regfile import rv_core_pkg::*; (
  input  logic     clk,
  input  logic     i_rst_n,
  input  reg_idx_t i_rs1,
  input  reg_idx_t i_rs2,
  input  logic     i_wen,
  input  reg_idx_t i_rd,
  input  xlen_t    i_wdata,
  output xlen_t    o_rs1_data,
  output xlen_t    o_rs2_data
);

  xlen_t regs [1:31];

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  // decode drops rd_wen for x0
  a_no_x0_write: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wen |-> (i_rd != '0));

endmodule

// File: logic/rv_core_pkg.sv
// shared widths, opcodes, enums and special encodings, imported by every core module
package rv_core_pkg;

  ////////////////////
  // data widths

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  ////////////////////
  // enums

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [2:0] {
    KIND_PLAIN  = 3'd0,
    KIND_BRANCH = 3'd1,
    KIND_JAL    = 3'd2,
    KIND_JALR   = 3'd3,
    KIND_PUTCH  = 3'd4
  } ctrl_kind_e;

  typedef enum logic {
    FS_REQ  = 1'b0,
    FS_WAIT = 1'b1
  } fetch_state_e;

  ////////////////////
  // opcodes

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // putch a0, emits the low byte of x10
  localparam inst_t    PUTCH_INST = 32'h0000007b;
  localparam reg_idx_t REG_A0     = 5'd10;

  localparam xlen_t INST_BYTES = 64'd4;

endpackage
